// ==== logic/ttc_params.svh ====
// Build-time constants of the triple timer/counter
// Include wherever timer count, counter width or register offsets are needed
// Register offsets are byte offsets, timer n sits at offset + 4n

`ifndef TTC_PARAMS_SVH
`define TTC_PARAMS_SVH

// Sizing
`define TTC_NUM_TIMERS 3             // Identical timers in the block
`define TTC_CNT_W      16            // Counter, interval and match width

// --------------------
// Register group base offsets
`define TTC_OFS_CLK_CTRL  8'h00
`define TTC_OFS_CNTR_CTRL 8'h0C
`define TTC_OFS_COUNTER   8'h18      // Read only
`define TTC_OFS_INTERVAL  8'h24
`define TTC_OFS_MATCH1    8'h30
`define TTC_OFS_MATCH2    8'h3C
`define TTC_OFS_MATCH3    8'h48
`define TTC_OFS_IRQ_STAT  8'h54      // Read only, cleared on read
`define TTC_OFS_IRQ_EN    8'h60

`endif

// ==== logic/ttc_pkg.sv ====
// Shared types of the triple timer/counter
// Holds the register vector types, the per-timer structs and the address decode
// used by both the write decoder and the read-back mux

`include "ttc_params.svh"

package ttc_pkg;

   // Bus types
   typedef logic [7:0]  apb_addr_t;
   typedef logic [31:0] apb_data_t;

   // Register types
   typedef logic [`TTC_CNT_W-1:0] count_t;    // Counter, interval, match
   typedef logic [6:0] clk_ctrl_t;            // [0] prescale en, [4:1] P
   typedef logic [6:0] cntr_ctrl_t;           // stop, intv, decr, match en, rst
   typedef logic [5:0] irq_flags_t;           // intv, match1..3, overflow, rsvd
   typedef logic [$clog2(`TTC_NUM_TIMERS)-1:0] tmr_idx_t;

   // --------------------
   // Register groups
   localparam int unsigned NUM_GRPS       = 9;
   localparam int unsigned GRP_CLK_CTRL   = 0;
   localparam int unsigned GRP_CNTR_CTRL  = 1;
   localparam int unsigned GRP_COUNTER    = 2;
   localparam int unsigned GRP_INTERVAL   = 3;
   localparam int unsigned GRP_MATCH1     = 4;
   localparam int unsigned GRP_MATCH2     = 5;
   localparam int unsigned GRP_MATCH3     = 6;
   localparam int unsigned GRP_IRQ_STAT   = 7;
   localparam int unsigned GRP_IRQ_EN     = 8;

   typedef logic [NUM_GRPS-1:0] grp_sel_t;    // One-hot, bit = group index

   // Group base offsets in group index order
   localparam apb_addr_t GRP_OFS [NUM_GRPS] = '{
      `TTC_OFS_CLK_CTRL, `TTC_OFS_CNTR_CTRL, `TTC_OFS_COUNTER,
      `TTC_OFS_INTERVAL, `TTC_OFS_MATCH1,    `TTC_OFS_MATCH2,
      `TTC_OFS_MATCH3,   `TTC_OFS_IRQ_STAT,  `TTC_OFS_IRQ_EN
   };

   // Decoder to one timer
   typedef struct packed {
      grp_sel_t wr_sel;                       // Write strobe per group
      logic     read_clear;                   // IRQ_STAT read in access phase
   } timer_wr_t;

   // Readable state of one timer
   typedef struct packed {
      clk_ctrl_t  clk_ctrl;
      cntr_ctrl_t cntr_ctrl;
      count_t     counter;
      count_t     interval;
      count_t     match1;
      count_t     match2;
      count_t     match3;
      irq_flags_t irq_stat;
      irq_flags_t irq_en;
   } timer_regs_t;

   // Result of an address decode
   typedef struct packed {
      logic     hit;                          // Mapped register
      grp_sel_t grp;
      tmr_idx_t tmr;
   } addr_dec_t;

   // Exact match on group base + 4n, misaligned or unmapped gives no hit
   function automatic addr_dec_t addr_decode(apb_addr_t addr);
      addr_dec_t d;
      d = '0;
      for (int g = 0; g < NUM_GRPS; g++) begin
         for (int t = 0; t < `TTC_NUM_TIMERS; t++) begin
            if (addr == GRP_OFS[g] + apb_addr_t'(4 * t)) begin
               d.hit    = 1'b1;
               d.grp[g] = 1'b1;
               d.tmr    = tmr_idx_t'(t);
            end
         end
      end
      return d;
   endfunction

endpackage

// ==== logic/ttc_apb_decode.sv ====
// APB write and read-clear decode for the triple timer/counter
// Turns an APB access phase into one write strobe set per timer, plus the
// pulse that clears a timer's interrupt status when it is read
// No wait states, so every access completes in its access phase

`include "ttc_params.svh"

module ttc_apb_decode (
   input  logic                                    pclk,
   input  logic                                    rst_n,
   input  logic                                    psel,
   input  logic                                    penable,
   input  logic                                    pwrite,
   input  ttc_pkg::apb_addr_t                      paddr,
   output ttc_pkg::timer_wr_t [`TTC_NUM_TIMERS-1:0] timer_wr
);

   import ttc_pkg::*;

   logic      wr_acc;                         // Write access phase
   logic      rd_acc;                         // Read access phase
   addr_dec_t dec;                            // Group and timer of paddr
   logic      [`TTC_NUM_TIMERS-1:0] tmr_hit;  // Address hits timer n

   assign wr_acc = psel & penable & pwrite;
   assign rd_acc = psel & penable & ~pwrite;

   // Word address split into group and timer index
   assign dec = addr_decode(paddr);

   // --------------------
   // Per-timer strobes
   always_comb begin
      for (int t = 0; t < `TTC_NUM_TIMERS; t++) begin
         tmr_hit[t] = dec.hit && (dec.tmr == tmr_idx_t'(t));

         timer_wr[t].wr_sel     = (wr_acc && tmr_hit[t]) ? dec.grp : '0;
         timer_wr[t].read_clear = rd_acc && tmr_hit[t] && dec.grp[GRP_IRQ_STAT];
      end
   end

   // --------------------
   // Checks

   // One register per access across the whole block
   a_sel_onehot: assert property (
      @(posedge pclk) disable iff (!rst_n)
      $onehot0(timer_wr)
   ) else $error("more than one timer register selected");

endmodule

// ==== logic/ttc_timer_counter.sv ====
// One 16-bit timer/counter of the triple timer
// Holds its configuration registers, a power-of-two prescaler, the counter
// with interval reload and wrap detection, and the sticky interrupt status
// Written through the strobes from the APB decoder, read back through regs

`include "ttc_params.svh"

module ttc_timer_counter (
   input  logic                 pclk,
   input  logic                 rst_n,
   input  ttc_pkg::count_t      wdata,
   input  ttc_pkg::timer_wr_t   wr,
   output ttc_pkg::timer_regs_t regs
);

   import ttc_pkg::*;

   // Configuration
   clk_ctrl_t  clk_ctrl;
   cntr_ctrl_t cntr_ctrl;                     // Bit 4 held at 0
   count_t     interval;
   count_t     match1;
   count_t     match2;
   count_t     match3;
   irq_flags_t irq_en;

   // Live state
   count_t     counter;
   count_t     cnt_next;                      // Value at the next tick
   count_t     ps_cnt;                        // Prescale cycle count
   count_t     ps_mask;                       // Terminal prescale count
   irq_flags_t irq_stat;
   irq_flags_t ev;                            // Events of this edge

   // Decoded control fields
   logic       ps_en;
   logic [3:0] ps_val;
   logic       stop;
   logic       intv_mode;
   logic       decr;
   logic       match_en;
   logic       cnt_rst;                       // Self-clearing counter reset
   logic       tick;                          // Prescaler output
   logic       run_tick;                      // Counter advances this edge

   assign ps_en     = clk_ctrl[0];
   assign ps_val    = clk_ctrl[4:1];
   assign stop      = cntr_ctrl[0];
   assign intv_mode = cntr_ctrl[1];
   assign decr      = cntr_ctrl[2];
   assign match_en  = cntr_ctrl[3];

   assign cnt_rst = wr.wr_sel[GRP_CNTR_CTRL] & wdata[4];

   // --------------------
   // Register writes
   always_ff @(posedge pclk or negedge rst_n) begin
      if (!rst_n) begin
         clk_ctrl  <= '0;
         cntr_ctrl <= 7'h01;                  // Stopped out of reset
         interval  <= '0;
         match1    <= '0;
         match2    <= '0;
         match3    <= '0;
         irq_en    <= '0;
      end else begin
         if (wr.wr_sel[GRP_CLK_CTRL])  clk_ctrl  <= wdata[6:0];
         if (wr.wr_sel[GRP_CNTR_CTRL]) cntr_ctrl <= {wdata[6:5], 1'b0, wdata[3:0]};
         if (wr.wr_sel[GRP_INTERVAL])  interval  <= wdata;
         if (wr.wr_sel[GRP_MATCH1])    match1    <= wdata;
         if (wr.wr_sel[GRP_MATCH2])    match2    <= wdata;
         if (wr.wr_sel[GRP_MATCH3])    match3    <= wdata;
         if (wr.wr_sel[GRP_IRQ_EN])    irq_en    <= {1'b0, wdata[4:0]}; // Bit 5 reserved
      end
   end

   // --------------------
   // Prescaler, one tick per 2^(P+1) cycles when enabled
   assign ps_mask  = count_t'((17'd2 << ps_val) - 17'd1);
   assign tick     = ps_en ? (ps_cnt == ps_mask) : 1'b1;
   assign run_tick = ~stop & tick;

   always_ff @(posedge pclk or negedge rst_n) begin
      if (!rst_n)
         ps_cnt <= '0;
      else if (stop || cnt_rst || tick)
         ps_cnt <= '0;                        // Restart the count
      else
         ps_cnt <= ps_cnt + 1'b1;
   end

   // --------------------
   // Next count and events
   always_comb begin
      cnt_next = counter;
      ev       = '0;
      if (decr) begin
         cnt_next = counter - 1'b1;
         if (counter == '0) begin
            if (intv_mode) begin
               cnt_next = interval;           // Reload
               ev[0]    = 1'b1;
            end else begin
               ev[4] = 1'b1;                  // Wrap below 0
            end
         end
      end else begin
         cnt_next = counter + 1'b1;
         if (intv_mode && counter >= interval) begin
            cnt_next = '0;
            ev[0]    = 1'b1;
         end else if (!intv_mode && counter == '1) begin
            ev[4] = 1'b1;                     // Wrap past 0xFFFF
         end
      end

      // Match against the value the tick produces
      ev[1] = match_en && (cnt_next == match1);
      ev[2] = match_en && (cnt_next == match2);
      ev[3] = match_en && (cnt_next == match3);

      if (!run_tick) ev = '0;                 // Events only on a counting edge
   end

   always_ff @(posedge pclk or negedge rst_n) begin
      if (!rst_n)
         counter <= '0;
      else if (cnt_rst)
         counter <= (wdata[1] && wdata[2]) ? interval : '0; // Start value
      else if (run_tick)
         counter <= cnt_next;
   end

   // Sticky status, an event on the clearing edge survives
   always_ff @(posedge pclk or negedge rst_n) begin
      if (!rst_n)
         irq_stat <= '0;
      else
         irq_stat <= (wr.read_clear ? '0 : irq_stat) | ev;
   end

   // --------------------
   // Read view
   assign regs.clk_ctrl  = clk_ctrl;
   assign regs.cntr_ctrl = cntr_ctrl;
   assign regs.counter   = counter;
   assign regs.interval  = interval;
   assign regs.match1    = match1;
   assign regs.match2    = match2;
   assign regs.match3    = match3;
   assign regs.irq_stat  = irq_stat;
   assign regs.irq_en    = irq_en;

   // --------------------
   // Checks

   // Up-counting interval mode stays within the interval once inside it
   a_intv_bound: assert property (
      @(posedge pclk) disable iff (!rst_n)
      (intv_mode && !decr && counter <= interval && !wr.wr_sel[GRP_INTERVAL])
         |=> (counter <= interval)
   ) else $error("counter above interval in interval up-mode");

   // Reserved status bit never set
   a_rsvd_zero: assert property (
      @(posedge pclk) disable iff (!rst_n)
      !irq_stat[5]
   ) else $error("reserved status bit set");

endmodule

// ==== logic/ttc_readback.sv ====
// Read-back and interrupt stage of the triple timer/counter
// Puts the register addressed by paddr onto prdata, zero-extended
// Unmapped addresses read zero; one interrupt line per timer

`include "ttc_params.svh"

module ttc_readback (
   input  ttc_pkg::apb_addr_t                        paddr,
   input  ttc_pkg::timer_regs_t [`TTC_NUM_TIMERS-1:0] regs,
   output ttc_pkg::apb_data_t                        prdata,
   output logic [`TTC_NUM_TIMERS-1:0]                interrupt
);

   import ttc_pkg::*;

   addr_dec_t   dec;                          // Group and timer of paddr
   timer_regs_t sel_regs;                     // Addressed timer

   assign dec      = addr_decode(paddr);
   assign sel_regs = regs[dec.tmr];

   // --------------------
   // Register mux
   always_comb begin
      prdata = '0;
      if (dec.hit) begin
         case (1'b1)
            dec.grp[GRP_CLK_CTRL]:  prdata = apb_data_t'(sel_regs.clk_ctrl);
            dec.grp[GRP_CNTR_CTRL]: prdata = apb_data_t'(sel_regs.cntr_ctrl);
            dec.grp[GRP_COUNTER]:   prdata = apb_data_t'(sel_regs.counter);
            dec.grp[GRP_INTERVAL]:  prdata = apb_data_t'(sel_regs.interval);
            dec.grp[GRP_MATCH1]:    prdata = apb_data_t'(sel_regs.match1);
            dec.grp[GRP_MATCH2]:    prdata = apb_data_t'(sel_regs.match2);
            dec.grp[GRP_MATCH3]:    prdata = apb_data_t'(sel_regs.match3);
            dec.grp[GRP_IRQ_STAT]:  prdata = apb_data_t'(sel_regs.irq_stat);
            dec.grp[GRP_IRQ_EN]:    prdata = apb_data_t'(sel_regs.irq_en);
            default:                prdata = '0;
         endcase
      end
   end

   // --------------------
   // Interrupt lines
   always_comb begin
      for (int t = 0; t < `TTC_NUM_TIMERS; t++) begin
         interrupt[t] = |(regs[t].irq_stat & regs[t].irq_en); // Enabled flags
      end
   end

endmodule

// ==== logic/ttc_lite.sv ====
// Top level of the APB triple timer/counter
// Connect to an APB bus without wait states; one interrupt line per timer
// Address map and widths come from the params header

`include "ttc_params.svh"

module ttc_lite (
   input  logic                              pclk,
   input  logic                              rst_n,
   input  logic                              psel,
   input  logic                              penable,
   input  logic                              pwrite,
   input  ttc_pkg::apb_addr_t                paddr,
   input  ttc_pkg::apb_data_t                pwdata,
   output ttc_pkg::apb_data_t                prdata,
   output logic [`TTC_NUM_TIMERS-1:0]        interrupt
);

   import ttc_pkg::*;

   // --------------------
   // Interconnect
   timer_wr_t   [`TTC_NUM_TIMERS-1:0] timer_wr;   // Decoder to timers
   timer_regs_t [`TTC_NUM_TIMERS-1:0] timer_regs; // Timers to read-back

   // Address decode
   ttc_apb_decode i_apb_decode (
      .pclk     (pclk),
      .rst_n    (rst_n),
      .psel     (psel),
      .penable  (penable),
      .pwrite   (pwrite),
      .paddr    (paddr),
      .timer_wr (timer_wr)
   );

   // --------------------
   // Timers, low half of the write data only
   for (genvar i = 0; i < `TTC_NUM_TIMERS; i++) begin : g_timer
      ttc_timer_counter i_timer (
         .pclk  (pclk),
         .rst_n (rst_n),
         .wdata (pwdata[`TTC_CNT_W-1:0]),
         .wr    (timer_wr[i]),
         .regs  (timer_regs[i])
      );
   end

   // Read-back and interrupts
   ttc_readback i_readback (
      .paddr     (paddr),
      .regs      (timer_regs),
      .prdata    (prdata),
      .interrupt (interrupt)
   );

endmodule

// ==== dv/ttc_clk_gen.sv ====
// Clock and reset source for the timer testbench
// Free-running pclk, rst_n held low for a set number of cycles from time 0

module ttc_clk_gen #(
   parameter int PERIOD     = 40,
   parameter int RST_CYCLES = 8
) (
   output logic pclk,
   output logic rst_n
);

   initial begin
      pclk = 1'b0;
      forever #(PERIOD / 2) pclk = ~pclk;
   end

   // Release on a falling edge, away from the DUT sampling edge
   initial begin
      rst_n = 1'b0;
      repeat (RST_CYCLES) @(posedge pclk);
      @(negedge pclk);
      rst_n = 1'b1;
   end

endmodule

// ==== dv/ttc_tb.sv ====
// Table-driven testbench of the APB triple timer/counter
// Builds a table of APB writes, reads and idle gaps with expected read data
// and interrupt lines, then plays it against the DUT on the falling edge
// Run through run.sh; the closing lines give the error counts and the verdict

`include "ttc_params.svh"

module ttc_tb;

   import ttc_pkg::*;

   localparam int         PERIOD  = 40;
   localparam logic [1:0] OP_WR   = 2'd0;
   localparam logic [1:0] OP_RD   = 2'd1;
   localparam logic [1:0] OP_IDLE = 2'd2;

   typedef logic [`TTC_NUM_TIMERS-1:0] irq_vec_t;

   typedef struct packed {
      logic [1:0] op;
      apb_addr_t  addr;
      apb_data_t  data;                       // Write data or idle cycles
      apb_data_t  exp_rd;
      irq_vec_t   exp_irq;
   } step_t;

   // Writable registers and their widths
   localparam apb_addr_t RW_OFS [6] = '{`TTC_OFS_CLK_CTRL, `TTC_OFS_INTERVAL,
      `TTC_OFS_MATCH1, `TTC_OFS_MATCH2, `TTC_OFS_MATCH3, `TTC_OFS_IRQ_EN};
   localparam apb_data_t RW_MASK [6] = '{32'h7F, 32'hFFFF, 32'hFFFF, 32'hFFFF,
      32'hFFFF, 32'h1F};

   logic      pclk;
   logic      rst_n;
   logic      psel;
   logic      penable;
   logic      pwrite;
   apb_addr_t paddr;
   apb_data_t pwdata;
   apb_data_t prdata;
   irq_vec_t  interrupt;

   step_t     steps[$];
   int        seed     = 32'had79;
   int        rd_errs  = 0;
   int        irq_errs = 0;
   longint    wd_limit = 0;                   // Set once the table is built

   ttc_clk_gen #(.PERIOD(PERIOD), .RST_CYCLES(8)) i_clk_gen (.pclk(pclk), .rst_n(rst_n));

   ttc_lite ttc_lite_inst (
      .pclk      (pclk),
      .rst_n     (rst_n),
      .psel      (psel),
      .penable   (penable),
      .pwrite    (pwrite),
      .paddr     (paddr),
      .pwdata    (pwdata),
      .prdata    (prdata),
      .interrupt (interrupt)
   );

   // --------------------
   // Table entries
   function automatic apb_addr_t reg_addr(apb_addr_t ofs, int t);
      return ofs + apb_addr_t'(4 * t);        // Timer n at group + 4n
   endfunction

   function automatic void write_step(apb_addr_t addr, apb_data_t data);
      steps.push_back(step_t'{OP_WR, addr, data, 32'h0, '0});
   endfunction

   function automatic void read_step(apb_addr_t addr, apb_data_t exp_rd, irq_vec_t exp_irq);
      steps.push_back(step_t'{OP_RD, addr, 32'h0, exp_rd, exp_irq});
   endfunction

   function automatic void idle_step(int cycles);
      steps.push_back(step_t'{OP_IDLE, 8'h00, apb_data_t'(cycles), 32'h0, '0});
   endfunction

   // --------------------
   // Bus tasks driven on the falling edge
   task automatic write_reg(input apb_addr_t addr, input apb_data_t data);
      @(negedge pclk);
      psel    = 1'b1;                         // Setup phase
      penable = 1'b0;
      pwrite  = 1'b1;
      paddr   = addr;
      pwdata  = data;
      @(negedge pclk);
      penable = 1'b1;                         // Write lands on the next rising edge
   endtask

   task automatic read_reg(input apb_addr_t addr, output apb_data_t rd, output irq_vec_t irq);
      @(negedge pclk);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = addr;
      @(negedge pclk);
      penable = 1'b1;
      #(PERIOD / 4);                          // Mid low phase before the clearing edge
      rd  = prdata;
      irq = interrupt;
   endtask

   task automatic bus_idle(input int cycles);
      repeat (cycles) begin
         @(negedge pclk);
         psel    = 1'b0;
         penable = 1'b0;
         pwrite  = 1'b0;
      end
   endtask

   // --------------------
   // Compare tasks
   task automatic rdata_compare(input apb_addr_t addr, input apb_data_t got, input apb_data_t exp);
      if (got !== exp) begin
         rd_errs++;
         $display("Error at %0t: prdata at 0x%h is %h, expected %h", $time, addr, got, exp);
      end
   endtask

   task automatic irq_compare(input irq_vec_t got, input irq_vec_t exp);
      if (got !== exp) begin
         irq_errs++;
         $display("Error at %0t: interrupt is %b, expected %b", $time, got, exp);
      end
   endtask

   // --------------------
   // Stimulus table with timing counted in rising edges after a write edge
   function automatic void build_table();
      apb_data_t d;
      int        ival;
      int        ps_p;
      int        ps_idle;
      ival    = 5;
      ps_p    = 1;
      ps_idle = 10;

      // Reset values with all timers stopped
      read_step(reg_addr(`TTC_OFS_CLK_CTRL, 0), 32'h0, 3'b000);
      for (int t = 0; t < `TTC_NUM_TIMERS; t++) begin
         read_step(reg_addr(`TTC_OFS_CNTR_CTRL, t), 32'h1, 3'b000);
      end
      read_step(reg_addr(`TTC_OFS_COUNTER, 2), 32'h0, 3'b000);
      read_step(reg_addr(`TTC_OFS_IRQ_STAT, 1), 32'h0, 3'b000);
      read_step(reg_addr(`TTC_OFS_IRQ_EN, 2), 32'h0, 3'b000);

      // Random read-back masked to register width
      for (int t = 0; t < `TTC_NUM_TIMERS; t++) begin
         for (int g = 0; g < 6; g++) begin
            d = $random(seed);
            write_step(reg_addr(RW_OFS[g], t), d);
            read_step(reg_addr(RW_OFS[g], t), d & RW_MASK[g], 3'b000);
         end
      end
      write_step(8'h6C, 32'hFFFF_FFFF);       // Past the map
      read_step(8'h6C, 32'h0, 3'b000);
      read_step(reg_addr(`TTC_OFS_IRQ_EN, 2), d & RW_MASK[5], 3'b000); // Last mapped write intact
      read_step(8'h02, 32'h0, 3'b000);        // Misaligned
      read_step(8'hFC, 32'h0, 3'b000);

      // Stop and counter reset on timer 0
      for (int t = 0; t < `TTC_NUM_TIMERS; t++) write_step(reg_addr(`TTC_OFS_IRQ_EN, t), 32'h0);
      write_step(reg_addr(`TTC_OFS_CLK_CTRL, 0), 32'h0);
      write_step(reg_addr(`TTC_OFS_CNTR_CTRL, 0), 32'h00);    // Run, up, free
      idle_step(4);
      write_step(reg_addr(`TTC_OFS_CNTR_CTRL, 0), 32'h01);    // Stop edge still counts to 6
      idle_step(5);
      read_step(reg_addr(`TTC_OFS_COUNTER, 0), 32'd6, 3'b000);
      write_step(reg_addr(`TTC_OFS_CNTR_CTRL, 0), 32'h11);    // Stop plus counter reset
      read_step(reg_addr(`TTC_OFS_COUNTER, 0), 32'h0, 3'b000);
      read_step(reg_addr(`TTC_OFS_CNTR_CTRL, 0), 32'h01, 3'b000);
      write_step(reg_addr(`TTC_OFS_INTERVAL, 0), 32'h40);
      write_step(reg_addr(`TTC_OFS_CNTR_CTRL, 0), 32'h17);    // Down in interval mode
      read_step(reg_addr(`TTC_OFS_COUNTER, 0), 32'h40, 3'b000);
      read_step(reg_addr(`TTC_OFS_CNTR_CTRL, 0), 32'h07, 3'b000);

      // Interval mode on timer 1 wrapping on edge I+1
      write_step(reg_addr(`TTC_OFS_CLK_CTRL, 1), 32'h0);
      write_step(reg_addr(`TTC_OFS_INTERVAL, 1), ival);
      write_step(reg_addr(`TTC_OFS_CNTR_CTRL, 1), 32'h13);
      write_step(reg_addr(`TTC_OFS_CNTR_CTRL, 1), 32'h02);
      idle_step(ival);
      read_step(reg_addr(`TTC_OFS_COUNTER, 1), 32'h0, 3'b000);
      write_step(reg_addr(`TTC_OFS_CNTR_CTRL, 1), 32'h03);    // Stops after I+4 edges
      read_step(reg_addr(`TTC_OFS_INTERVAL, 1), ival, 3'b000); // Flag set but line masked
      write_step(reg_addr(`TTC_OFS_IRQ_EN, 1), 32'h01);
      read_step(reg_addr(`TTC_OFS_INTERVAL, 1), ival, 3'b010);
      read_step(reg_addr(`TTC_OFS_IRQ_STAT, 1), 32'h01, 3'b010);
      read_step(reg_addr(`TTC_OFS_IRQ_STAT, 1), 32'h0, 3'b000);
      read_step(reg_addr(`TTC_OFS_COUNTER, 1), (ival + 4) % (ival + 1), 3'b000);

      // Match events on timer 2
      write_step(reg_addr(`TTC_OFS_CLK_CTRL, 2), 32'h0);
      write_step(reg_addr(`TTC_OFS_IRQ_EN, 2), 32'h08);       // Match 3 drives the line
      write_step(reg_addr(`TTC_OFS_MATCH1, 2), 32'd2);
      write_step(reg_addr(`TTC_OFS_MATCH2, 2), 32'd4);
      write_step(reg_addr(`TTC_OFS_MATCH3, 2), 32'd6);
      write_step(reg_addr(`TTC_OFS_CNTR_CTRL, 2), 32'h11);
      write_step(reg_addr(`TTC_OFS_CNTR_CTRL, 2), 32'h00);    // Matches disabled
      idle_step(4);
      write_step(reg_addr(`TTC_OFS_CNTR_CTRL, 2), 32'h01);
      read_step(reg_addr(`TTC_OFS_IRQ_STAT, 2), 32'h0, 3'b000);
      write_step(reg_addr(`TTC_OFS_CNTR_CTRL, 2), 32'h19);    // Reset with match enable
      write_step(reg_addr(`TTC_OFS_CNTR_CTRL, 2), 32'h08);
      idle_step(4);
      write_step(reg_addr(`TTC_OFS_CNTR_CTRL, 2), 32'h09);
      read_step(reg_addr(`TTC_OFS_COUNTER, 2), 32'd6, 3'b100);
      read_step(reg_addr(`TTC_OFS_IRQ_STAT, 2), 32'h0E, 3'b100);
      read_step(reg_addr(`TTC_OFS_IRQ_STAT, 0), 32'h0, 3'b000); // Others untouched
      read_step(reg_addr(`TTC_OFS_IRQ_STAT, 1), 32'h0, 3'b000);
      read_step(reg_addr(`TTC_OFS_COUNTER, 1), (ival + 4) % (ival + 1), 3'b000);

      // Free-running decrement from 0 on timer 0
      write_step(reg_addr(`TTC_OFS_IRQ_EN, 0), 32'h10);
      write_step(reg_addr(`TTC_OFS_CNTR_CTRL, 0), 32'h15);
      read_step(reg_addr(`TTC_OFS_COUNTER, 0), 32'h0, 3'b000);
      write_step(reg_addr(`TTC_OFS_CNTR_CTRL, 0), 32'h04);
      write_step(reg_addr(`TTC_OFS_CNTR_CTRL, 0), 32'h05);    // Two edges
      read_step(reg_addr(`TTC_OFS_COUNTER, 0), 32'hFFFE, 3'b001);
      read_step(reg_addr(`TTC_OFS_IRQ_STAT, 0), 32'h10, 3'b001);
      read_step(reg_addr(`TTC_OFS_IRQ_STAT, 0), 32'h0, 3'b000);

      // Prescaler on timer 1
      write_step(reg_addr(`TTC_OFS_CLK_CTRL, 1), (ps_p << 1) | 1);
      write_step(reg_addr(`TTC_OFS_CNTR_CTRL, 1), 32'h11);
      write_step(reg_addr(`TTC_OFS_CNTR_CTRL, 1), 32'h00);
      idle_step(ps_idle);
      read_step(reg_addr(`TTC_OFS_COUNTER, 1), (ps_idle + 1) >> (ps_p + 1), 3'b000);
   endfunction

   // --------------------
   // Main sequence
   initial begin : stimulus
      apb_data_t got_rd;
      irq_vec_t  got_irq;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = '0;
      pwdata  = '0;
      build_table();
      wd_limit = (longint'(steps.size()) * PERIOD + 400) * PERIOD;
      wait (rst_n === 1'b1);
      foreach (steps[i]) begin
         case (steps[i].op)
            OP_WR: write_reg(steps[i].addr, steps[i].data);
            OP_RD: begin
               read_reg(steps[i].addr, got_rd, got_irq);
               rdata_compare(steps[i].addr, got_rd, steps[i].exp_rd);
               irq_compare(got_irq, steps[i].exp_irq);
            end
            default: bus_idle(int'(steps[i].data));
         endcase
      end
      bus_idle(1);
      $display("Errors: prdata %0d, interrupt %0d", rd_errs, irq_errs);
      if (rd_errs + irq_errs == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

   // Watchdog sized from the table length
   initial begin : watchdog
      wait (wd_limit > 0);
      #(wd_limit);
      $display("Watchdog expired before the stimulus table finished");
      $display("Regression failed");
      $finish;
   end

endmodule

// ==== compile.f ====
+incdir+logic
logic/ttc_pkg.sv
logic/ttc_apb_decode.sv
logic/ttc_timer_counter.sv
logic/ttc_readback.sv
logic/ttc_lite.sv
dv/ttc_clk_gen.sv
dv/ttc_tb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the timer testbench with Verilator, runs it and checks the log.
# Exit status is 0 only when the log holds the pass line.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module ttc_tb -f compile.f -o ttc_sim \
   && ./obj_dir/ttc_sim | tee sim.log
grep -qs "^Regression passed$" sim.log && echo "PASS" && exit 0 \
   || { echo "FAIL"; exit 1; }
